// ==== model.f ====
+incdir+include
hw/cnn_types_pkg.sv
hw/cnn_weights_pkg.sv
hw/conv_pos_counter.sv
hw/conv_line_buffer.sv
hw/conv_mac.sv
hw/conv_ctrl_fsm.sv
hw/conv2d.sv
hw/model.sv
verification/model_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line in the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module model_tb -f model.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vmodel_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    echo "run passed"
    exit 0
else
    echo "run failed"
    exit 1
fi

// ==== include/model_tb_ref.svh ====
// reference model of the two-layer convolution core with typed result checks
`ifndef MODEL_TB_REF_SVH
`define MODEL_TB_REF_SVH

// IMG_W and FRAC_N come from the including testbench
localparam int FMAP_W = IMG_W - KERNEL_SIZE + 1;
localparam int OUT_W = (FMAP_W - KERNEL_SIZE) / L2_STRIDE + 1;
localparam int OUT_PER_IMG = OUT_W * OUT_W;
localparam longint VAL_MAX = (longint'(1) <<< (VALUE_BITS - 1)) - 1;
localparam longint VAL_MIN = -VAL_MAX - 1;

// expected beats in the order the core hands them out
pix_beat_t exp_q [$];

// drop the fraction bits of a wide sum and clamp to the stream range
function automatic value_t scale_and_clamp(input longint sum);
    longint scaled;
    scaled = sum >>> FRAC_N;
    if (scaled > VAL_MAX)
        scaled = VAL_MAX;
    else if (scaled < VAL_MIN)
        scaled = VAL_MIN;
    return value_t'(scaled);
endfunction

// both layers for one image, appends one beat per layer 2 window
function automatic void predict_image(input value_t src [IMG_W][IMG_W]);
    value_t    fmap [FMAP_W][FMAP_W][L1_OUT_CH];
    pix_beat_t beat;
    longint    sum;
    int        r0;
    int        c0;
    for (int r = 0; r < FMAP_W; r++) begin
        for (int c = 0; c < FMAP_W; c++) begin
            for (int oc = 0; oc < L1_OUT_CH; oc++) begin
                sum = longint'(L1_BIAS[oc]) <<< FRAC_N;
                for (int i = 0; i < KERNEL_SIZE; i++) begin
                    for (int j = 0; j < KERNEL_SIZE; j++) begin
                        sum += longint'(L1_WEIGHTS[oc][0][i][j]) * longint'(src[r+i][c+j]);
                    end
                end
                fmap[r][c][oc] = scale_and_clamp(sum);
            end
        end
    end
    for (int oy = 0; oy < OUT_W; oy++) begin
        for (int ox = 0; ox < OUT_W; ox++) begin
            r0 = oy * L2_STRIDE;
            c0 = ox * L2_STRIDE;
            beat = '0;
            for (int oc = 0; oc < L2_OUT_CH; oc++) begin
                sum = longint'(L2_BIAS[oc]) <<< FRAC_N;
                for (int ic = 0; ic < L2_IN_CH; ic++) begin
                    for (int i = 0; i < KERNEL_SIZE; i++) begin
                        for (int j = 0; j < KERNEL_SIZE; j++) begin
                            sum += longint'(L2_WEIGHTS[oc][ic][i][j])
                                   * longint'(fmap[r0+i][c0+j][ic]);
                        end
                    end
                end
                beat.data[oc] = scale_and_clamp(sum);
            end
            beat.last = (oy == OUT_W - 1) && (ox == OUT_W - 1);
            exp_q.push_back(beat);
        end
    end
endfunction

task automatic check_beat(input pix_beat_t got, input pix_beat_t exp, input int idx);
    for (int ch = 0; ch < L2_OUT_CH; ch++) begin
        if (got.data[ch] !== exp.data[ch]) begin
            $display("error: %0d ns, output %0d channel %0d is %0d, expected %0d",
                     $time, idx, ch, got.data[ch], exp.data[ch]);
            stop_on_error();
        end
    end
endtask

task automatic check_last(input logic got, input logic exp, input int idx);
    if (got !== exp) begin
        $display("error: %0d ns, output %0d last is %b, expected %b", $time, idx, got, exp);
        stop_on_error();
    end
endtask

`endif

// ==== verification/model_tb.sv ====
// directed testbench for the two-layer streaming convolution core
`timescale 1ns/10ps
module model_tb
    import cnn_types_pkg::*;
    import cnn_weights_pkg::*;
;
    localparam int IMG_W = 8;
    localparam int FRAC_N = FRAC_BITS;
    localparam int RESET_CYCLES = 8;
    localparam int WAIT_LIMIT = 2000;
    localparam int QUIET_CYCLES = 200;

    logic      clk;
    logic      i_rst_n;
    pix_beat_t i_beat;
    logic      i_valid;
    logic      o_ready;
    pix_beat_t o_beat;
    logic      o_valid;
    logic      i_out_ready;

    int        seed;
    int        errors;
    value_t    img_a [IMG_W][IMG_W];
    value_t    img_b [IMG_W][IMG_W];

    `include "model_tb_ref.svh"

    model #(.IMG_WIDTH(IMG_W), .N(FRAC_N)) model_inst (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_beat     (i_beat),
        .i_valid    (i_valid),
        .o_ready    (o_ready),
        .o_beat     (o_beat),
        .o_valid    (o_valid),
        .i_out_ready(i_out_ready)
    );

    always #50 clk = ~clk;

    task automatic stop_on_error();
        errors++;
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error: %0d ns, %s is %b, expected %b", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    // caller sits on a falling edge, returns on the falling edge after the transfer
    task automatic send_image(input value_t src [IMG_W][IMG_W]);
        int waited;
        for (int r = 0; r < IMG_W; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                waited = 0;
                i_beat = '0;
                i_beat.data[0] = src[r][c];
                i_beat.last = (r == IMG_W - 1) && (c == IMG_W - 1);
                i_valid = 1'b1;
                while (!o_ready) begin
                    @(negedge clk);
                    waited++;
                    if (waited > WAIT_LIMIT) begin
                        $display("timeout: input ready stayed low at pixel %0d,%0d", r, c);
                        stop_on_error();
                    end
                end
                @(negedge clk);
            end
        end
        i_valid = 1'b0;
    endtask

    task automatic collect_outputs(input int count, input bit stall);
        pix_beat_t beat;
        pix_beat_t expected;
        int        got_n;
        int        idle;
        got_n = 0;
        idle = 0;
        while (got_n < count) begin
            @(negedge clk);
            i_out_ready = stall ? (($random(seed) & 1) == 1) : 1'b1;
            if (o_valid && i_out_ready) begin
                beat = o_beat;
                expected = exp_q.pop_front();
                check_beat(beat, expected, got_n);
                check_last(beat.last, expected.last, got_n);
                got_n++;
                idle = 0;
            end else begin
                idle++;
                if (idle > WAIT_LIMIT) begin
                    $display("timeout: output %0d of %0d never arrived", got_n, count);
                    stop_on_error();
                end
            end
        end
    endtask

    task automatic stream_images(input int count, input bit stall);
        @(negedge clk);
        fork
            begin
                send_image(img_a);
                if (count > 1)
                    send_image(img_b);
            end
            collect_outputs(count * OUT_PER_IMG, stall);
        join
        // the core must stay quiet once every window has been handed out
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            if (o_valid) begin
                $display("an extra output appeared after the last expected one");
                stop_on_error();
            end
        end
    endtask

    task automatic fill_image(output value_t dst [IMG_W][IMG_W], input int kind);
        for (int r = 0; r < IMG_W; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                // kind 0 zero, 1 random, 2 full scale
                if (kind == 1)
                    dst[r][c] = value_t'($random(seed) % 16384);
                else if (kind == 2)
                    dst[r][c] = value_t'(VAL_MAX);
                else
                    dst[r][c] = '0;
            end
        end
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_flag(o_valid, 1'b0, "o_valid after reset");
        check_flag(o_ready, 1'b1, "o_ready after reset");
    endtask

    task automatic test_image(input int kind, input bit stall);
        if (kind >= 0)
            fill_image(img_a, kind);
        exp_q.delete();
        predict_image(img_a);
        stream_images(1, stall);
    endtask

    task automatic test_impulse_image();
        fill_image(img_a, 0);
        // one pixel of 1.0 away from the border
        img_a[3][4] = value_t'(1) <<< FRAC_N;
        test_image(-1, 1'b0);
    endtask

    task automatic test_saturation_back_to_back();
        fill_image(img_a, 2);
        fill_image(img_b, 1);
        exp_q.delete();
        predict_image(img_a);
        predict_image(img_b);
        stream_images(2, 1'b0);
    endtask

    initial begin
        clk = 1'b0;
        i_rst_n = 1'b0;
        i_beat = '0;
        i_valid = 1'b0;
        i_out_ready = 1'b0;
        seed = 31;
        errors = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;

        test_reset_state();
        test_image(0, 1'b0);
        test_impulse_image();
        test_image(1, 1'b0);
        // same random image again under output stalls
        test_image(-1, 1'b1);
        test_saturation_back_to_back();

        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== hw/model.sv ====
// two-layer streaming convolution core for single-channel square images
`timescale 1ns/10ps
module model
    import cnn_types_pkg::*;
    import cnn_weights_pkg::*;
#(
    parameter int IMG_WIDTH = 8,
    parameter int N         = FRAC_BITS
) (
    input  logic      clk,
    input  logic      i_rst_n,
    input  pix_beat_t i_beat,
    input  logic      i_valid,
    output logic      o_ready,
    output pix_beat_t o_beat,
    output logic      o_valid,
    input  logic      i_out_ready
);
    // layer 2 sees the unpadded layer 1 map
    localparam int L2_WIDTH = IMG_WIDTH - KERNEL_SIZE + 1;

    pix_beat_t l1_beat;
    logic      l1_valid;
    logic      l2_ready;

    conv2d #(
        .LAYER (1),
        .WIDTH (IMG_WIDTH),
        .STRIDE(L1_STRIDE),
        .IN_CH (L1_IN_CH),
        .OUT_CH(L1_OUT_CH),
        .N     (N)
    ) u_layer1 (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_beat     (i_beat),
        .i_valid    (i_valid),
        .o_ready    (o_ready),
        .o_beat     (l1_beat),
        .o_valid    (l1_valid),
        .i_out_ready(l2_ready)
    );

    conv2d #(
        .LAYER (2),
        .WIDTH (L2_WIDTH),
        .STRIDE(L2_STRIDE),
        .IN_CH (L2_IN_CH),
        .OUT_CH(L2_OUT_CH),
        .N     (N)
    ) u_layer2 (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_beat     (l1_beat),
        .i_valid    (l1_valid),
        .o_ready    (l2_ready),
        .o_beat     (o_beat),
        .o_valid    (o_valid),
        .i_out_ready(i_out_ready)
    );

endmodule

// ==== hw/conv2d.sv ====
// one streaming 3x3 convolution layer with valid/ready on both sides
`timescale 1ns/10ps
module conv2d
    import cnn_types_pkg::*;
    import cnn_weights_pkg::*;
#(
    parameter int LAYER  = 1,
    parameter int WIDTH  = 8,
    parameter int STRIDE = 1,
    parameter int IN_CH  = 1,
    parameter int OUT_CH = 2,
    parameter int N      = FRAC_BITS
) (
    input  logic      clk,
    input  logic      i_rst_n,
    input  pix_beat_t i_beat,
    input  logic      i_valid,
    output logic      o_ready,
    output pix_beat_t o_beat,
    output logic      o_valid,
    input  logic      i_out_ready
);
    localparam int CW = $clog2(WIDTH);

    logic               accept;
    logic [CW-1:0]      col;
    logic [CW-1:0]      row;
    logic               window_done;
    logic               image_done;
    mac_op_e            mac_op;
    logic [1:0]         tap_row;
    logic [1:0]         tap_col;
    logic [CH_BITS-1:0] tap_ch;
    logic [CH_BITS-1:0] out_ch;
    value_t             tap_val;
    value_t             mac_result;
    weight_t            coeff;
    pix_beat_t          fsm_beat;
    logic               fsm_last;

    assign accept = i_valid && o_ready;

    // bias rides the coefficient port during a bias load
    always_comb begin
        if (mac_op == MAC_LOAD_BIAS)
            coeff = layer_bias(LAYER, int'(out_ch));
        else
            coeff = layer_weight(LAYER, int'(out_ch), int'(tap_ch), int'(tap_row),
                                 int'(tap_col));
    end

    // an input last realigns the position to the image start
    conv_pos_counter #(.WIDTH(WIDTH), .STRIDE(STRIDE)) u_pos (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_step       (accept),
        .i_clear      (accept && i_beat.last),
        .o_col        (col),
        .o_row        (row),
        .o_window_done(window_done),
        .o_image_done (image_done)
    );

    conv_line_buffer #(.WIDTH(WIDTH), .IN_CH(IN_CH)) u_lines (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_wr_en  (accept),
        .i_col    (col),
        .i_row    (row),
        .i_beat   (i_beat),
        .i_tap_row(tap_row),
        .i_tap_col(tap_col),
        .i_tap_ch (tap_ch),
        .o_tap    (tap_val)
    );

    conv_mac #(.N(N)) u_mac (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_op    (mac_op),
        .i_coeff (coeff),
        .i_pixel (tap_val),
        .o_result(mac_result)
    );

    conv_ctrl_fsm #(.LAYER(LAYER), .IN_CH(IN_CH), .OUT_CH(OUT_CH)) u_ctrl (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (i_valid),
        .o_ready      (o_ready),
        .i_window_done(window_done),
        .i_image_done (image_done),
        .i_out_ready  (i_out_ready),
        .o_valid      (o_valid),
        .o_last       (fsm_last),
        .o_op         (mac_op),
        .o_tap_row    (tap_row),
        .o_tap_col    (tap_col),
        .o_tap_ch     (tap_ch),
        .o_out_ch     (out_ch),
        .i_result     (mac_result),
        .o_beat       (fsm_beat)
    );

    always_comb begin
        o_beat      = fsm_beat;
        o_beat.last = fsm_last;
    end

endmodule

// ==== hw/conv_ctrl_fsm.sv ====
// layer sequencer for pixel intake, per-channel tap sweep and result handoff
`timescale 1ns/10ps
module conv_ctrl_fsm
    import cnn_types_pkg::*;
#(
    parameter int LAYER  = 1,
    parameter int IN_CH  = 1,
    parameter int OUT_CH = 2
) (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_valid,
    output logic               o_ready,
    input  logic               i_window_done,
    input  logic               i_image_done,
    input  logic               i_out_ready,
    output logic               o_valid,
    output logic               o_last,
    output mac_op_e            o_op,
    output logic [1:0]         o_tap_row,
    output logic [1:0]         o_tap_col,
    output logic [CH_BITS-1:0] o_tap_ch,
    output logic [CH_BITS-1:0] o_out_ch,
    input  value_t             i_result,
    output pix_beat_t          o_beat
);
    ctrl_state_e        state;
    logic [CH_BITS-1:0] oc_q;
    logic [CH_BITS-1:0] ch_q;
    logic [1:0]         row_q;
    logic [1:0]         col_q;
    logic               bias_q;
    logic               fin_q;
    logic               last_q;
    logic               last_tap;
    logic               first_tap;
    value_t             res_q [MAX_CH];

    if (LAYER < 1 || LAYER > 2 || IN_CH > MAX_CH || OUT_CH > MAX_CH) begin : g_bad_cfg
        $error("conv_ctrl_fsm layer %0d has an unsupported configuration", LAYER);
    end

    assign o_ready   = (state == ST_FILL);
    assign o_valid   = (state == ST_OUT);
    assign o_last    = last_q;
    assign o_tap_row = row_q;
    assign o_tap_col = col_q;
    assign o_tap_ch  = ch_q;
    assign o_out_ch  = oc_q;

    assign last_tap  = (col_q == 2'd2) && (row_q == 2'd2) && (int'(ch_q) == IN_CH - 1);
    assign first_tap = (col_q == 2'd0) && (row_q == 2'd0) && (ch_q == '0);

    always_comb begin
        o_op = MAC_IDLE;
        if (state == ST_MAC) begin
            if (fin_q)
                o_op = MAC_FINISH;
            else if (bias_q)
                o_op = MAC_LOAD_BIAS;
            else
                o_op = MAC_ACC;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state  <= ST_FILL;
            oc_q   <= '0;
            ch_q   <= '0;
            row_q  <= '0;
            col_q  <= '0;
            bias_q <= 1'b0;
            fin_q  <= 1'b0;
            last_q <= 1'b0;
        end else begin
            case (state)
                ST_FILL: begin
                    if (i_valid && i_window_done) begin
                        state  <= ST_MAC;
                        oc_q   <= '0;
                        bias_q <= 1'b1;
                        fin_q  <= 1'b0;
                        last_q <= i_image_done;
                    end
                end
                ST_MAC: begin
                    if (fin_q) begin
                        state <= ST_OUT;
                    end else if (bias_q) begin
                        bias_q <= 1'b0;
                    end else if (last_tap) begin
                        col_q <= '0;
                        row_q <= '0;
                        ch_q  <= '0;
                        if (int'(oc_q) == OUT_CH - 1) begin
                            fin_q <= 1'b1;
                        end else begin
                            oc_q   <= oc_q + 1'b1;
                            bias_q <= 1'b1;
                        end
                    end else if (col_q == 2'd2) begin
                        col_q <= '0;
                        if (row_q == 2'd2) begin
                            row_q <= '0;
                            ch_q  <= ch_q + 1'b1;
                        end else begin
                            row_q <= row_q + 1'b1;
                        end
                    end else begin
                        col_q <= col_q + 1'b1;
                    end
                end
                ST_OUT: begin
                    if (i_out_ready)
                        state <= ST_FILL;
                end
                default: state <= ST_FILL;
            endcase
        end
    end

    // earlier channels are picked up on the first tap after their hand-off
    always_ff @(posedge clk) begin
        if (state == ST_MAC && !bias_q && !fin_q && first_tap && oc_q != '0)
            res_q[oc_q - 1'b1] <= i_result;
    end

    // final channel stays in the MAC result register until the next bias load
    always_comb begin
        o_beat = '0;
        for (int i = 0; i < OUT_CH - 1; i++) begin
            o_beat.data[i] = res_q[i];
        end
        o_beat.data[OUT_CH-1] = i_result;
    end

    // a stalled result keeps its beat until downstream takes it
    out_held_until_taken: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_valid && !i_out_ready) |=> (o_valid && $stable(o_beat) && $stable(o_last)));

endmodule

// ==== hw/conv_mac.sv ====
// sequential multiply-accumulate with bias preload, fraction shift and saturation
`timescale 1ns/10ps
module conv_mac
    import cnn_types_pkg::*;
    import cnn_weights_pkg::*;
#(
    parameter int N = FRAC_BITS
) (
    input  logic    clk,
    input  logic    i_rst_n,
    input  mac_op_e i_op,
    input  weight_t i_coeff,
    input  value_t  i_pixel,
    output value_t  o_result
);
    localparam acc_t SAT_MAX = (acc_t'(1) <<< (VALUE_BITS - 1)) - acc_t'(1);
    localparam acc_t SAT_MIN = -SAT_MAX - acc_t'(1);

    acc_t   acc;
    acc_t   scaled;
    value_t sat_val;

    // bias is scaled up to match the product fraction bits
    always_ff @(posedge clk) begin
        case (i_op)
            MAC_LOAD_BIAS: acc <= acc_t'(i_coeff) <<< N;
            MAC_ACC:       acc <= acc + acc_t'(i_coeff) * acc_t'(i_pixel);
            default: ;
        endcase
    end

    assign scaled = acc >>> N;

    always_comb begin
        if (scaled > SAT_MAX)
            sat_val = value_t'(SAT_MAX);
        else if (scaled < SAT_MIN)
            sat_val = value_t'(SAT_MIN);
        else
            sat_val = value_t'(scaled);
    end

    // a bias load also hands out the channel that just finished
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_result <= '0;
        else if (i_op == MAC_LOAD_BIAS || i_op == MAC_FINISH)
            o_result <= sat_val;
    end

    no_acc_after_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_op == MAC_IDLE) |=> (i_op != MAC_ACC));

endmodule

// ==== hw/conv_line_buffer.sv ====
// three-row circular pixel store per input channel with a combinational window tap
`timescale 1ns/10ps
module conv_line_buffer
    import cnn_types_pkg::*;
#(
    parameter int WIDTH = 8,
    parameter int IN_CH = 1
) (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_wr_en,
    input  logic [$clog2(WIDTH)-1:0] i_col,
    input  logic [$clog2(WIDTH)-1:0] i_row,
    input  pix_beat_t                i_beat,
    input  logic [1:0]               i_tap_row,
    input  logic [1:0]               i_tap_col,
    input  logic [CH_BITS-1:0]       i_tap_ch,
    output value_t                   o_tap
);
    localparam int CW = $clog2(WIDTH);

    value_t        mem [IN_CH][3][WIDTH];
    logic [1:0]    wr_slot;
    logic [1:0]    last_slot;
    logic [CW-1:0] last_col;
    logic [2:0]    slot_sum;
    logic [1:0]    rd_slot;
    logic [CW-1:0] rd_col;

    assign wr_slot = 2'(i_row % 3);

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            for (int ch = 0; ch < IN_CH; ch++) begin
                mem[ch][wr_slot][i_col] <= i_beat.data[ch];
            end
        end
    end

    // the tap window ends at the newest written pixel
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            last_slot <= '0;
            last_col  <= '0;
        end else if (i_wr_en) begin
            last_slot <= wr_slot;
            last_col  <= i_col;
        end
    end

    // top window row is the slot right after the newest row
    assign slot_sum = 3'(last_slot) + 3'd1 + 3'(i_tap_row);
    assign rd_slot  = (slot_sum >= 3'd3) ? 2'(slot_sum - 3'd3) : slot_sum[1:0];
    assign rd_col   = last_col - CW'(2) + CW'(i_tap_col);

    assign o_tap = mem[i_tap_ch][rd_slot][rd_col];

endmodule

// ==== hw/conv_pos_counter.sv ====
// pixel position counter that flags each completed stride-aligned 3x3 window
`timescale 1ns/10ps
module conv_pos_counter #(
    parameter int WIDTH = 8,
    parameter int STRIDE = 1
) (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_step,
    input  logic                     i_clear,
    output logic [$clog2(WIDTH)-1:0] o_col,
    output logic [$clog2(WIDTH)-1:0] o_row,
    output logic                     o_window_done,
    output logic                     o_image_done
);
    // bottom-right corner of the last window along a row or column
    localparam int LAST_POS = 2 + ((WIDTH - 3) / STRIDE) * STRIDE;

    logic col_hit;
    logic row_hit;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_col <= '0;
            o_row <= '0;
        end else if (i_clear) begin
            o_col <= '0;
            o_row <= '0;
        end else if (i_step) begin
            if (int'(o_col) == WIDTH - 1) begin
                o_col <= '0;
                if (int'(o_row) == WIDTH - 1)
                    o_row <= '0;
                else
                    o_row <= o_row + 1'b1;
            end else begin
                o_col <= o_col + 1'b1;
            end
        end
    end

    // window corner needs two rows and two columns behind it
    assign col_hit = (o_col >= 2) && (((int'(o_col) - 2) % STRIDE) == 0);
    assign row_hit = (o_row >= 2) && (((int'(o_row) - 2) % STRIDE) == 0);

    assign o_window_done = col_hit && row_hit;
    assign o_image_done  = o_window_done && (int'(o_col) == LAST_POS)
                           && (int'(o_row) == LAST_POS);

    col_in_range: assert property (@(posedge clk) disable iff (!i_rst_n)
        int'(o_col) < WIDTH);

endmodule

// ==== hw/cnn_weights_pkg.sv ====
// layer geometry and fixed coefficient tables for both convolution layers
package cnn_weights_pkg;

    localparam int KERNEL_SIZE = 3;

    localparam int L1_IN_CH = 1;
    localparam int L1_OUT_CH = 2;
    localparam int L1_STRIDE = 1;

    localparam int L2_IN_CH = L1_OUT_CH;
    localparam int L2_OUT_CH = 2;
    localparam int L2_STRIDE = 2;

    typedef logic signed [31:0] weight_t;

    // tables are indexed [out channel][in channel][row][col]
    // 4096 stands for 1.0
    localparam weight_t L1_WEIGHTS [L1_OUT_CH][L1_IN_CH][KERNEL_SIZE][KERNEL_SIZE] = '{
        '{'{'{1024, 1024, 1024}, '{1024, 4096, 1024}, '{1024, 1024, 1024}}},
        '{'{'{-2048, -2048, -2048}, '{-2048, 2048, -2048}, '{-2048, -2048, -2048}}}
    };

    localparam weight_t L1_BIAS [L1_OUT_CH] = '{512, -256};

    localparam weight_t L2_WEIGHTS [L2_OUT_CH][L2_IN_CH][KERNEL_SIZE][KERNEL_SIZE] = '{
        '{'{'{1024, 512, 1024}, '{512, 2048, 512}, '{1024, 512, 1024}},
          '{'{-512, 0, 512}, '{-1024, 0, 1024}, '{-512, 0, 512}}},
        '{'{'{256, 256, 256}, '{256, 256, 256}, '{256, 256, 256}},
          '{'{2048, -1024, 0}, '{-1024, 1024, 0}, '{0, 0, -2048}}}
    };

    localparam weight_t L2_BIAS [L2_OUT_CH] = '{-1024, 2048};

    function automatic weight_t layer_weight(input int layer, input int oc, input int ic,
                                             input int row, input int col);
        weight_t w;
        w = '0;
        if (layer == 1 && ic < L1_IN_CH)
            w = L1_WEIGHTS[oc][ic][row][col];
        else if (layer == 2)
            w = L2_WEIGHTS[oc][ic][row][col];
        return w;
    endfunction

    function automatic weight_t layer_bias(input int layer, input int oc);
        weight_t b;
        b = (layer == 1) ? L1_BIAS[oc] : L2_BIAS[oc];
        return b;
    endfunction

endpackage

// ==== hw/cnn_types_pkg.sv ====
// numeric, stream and control types shared by every convolution layer
package cnn_types_pkg;

    // stream values are signed fixed point with FRAC_BITS fraction bits
    localparam int VALUE_BITS = 18;
    localparam int FRAC_BITS = 12;

    // wide enough for bias plus 9 products per input channel
    localparam int ACC_BITS = 48;

    // widest channel vector a stream beat can carry
    localparam int MAX_CH = 2;
    localparam int CH_BITS = $clog2(MAX_CH);

    typedef logic signed [VALUE_BITS-1:0] value_t;
    typedef logic signed [ACC_BITS-1:0] acc_t;

    // one channel vector per transfer
    typedef struct packed {
        value_t [MAX_CH-1:0] data;
        logic                last;
    } pix_beat_t;

    typedef enum logic [1:0] {
        ST_FILL,
        ST_MAC,
        ST_OUT
    } ctrl_state_e;

    typedef enum logic [1:0] {
        MAC_IDLE,
        MAC_LOAD_BIAS,
        MAC_ACC,
        MAC_FINISH
    } mac_op_e;

endpackage
